// File: source/risc14_defs.svh
`ifndef RISC14_DEFS_SVH
`define RISC14_DEFS_SVH

// Datapath widths
`define RISC_WORD_W     14
`define RISC_LANE_W     7
`define RISC_REG_CNT    16
`define RISC_REG_IDX_W  4
`define RISC_SR_W       12
`define RISC_OPC_W      6

// APB widths and word index within PADDR
`define APB_ADDR_W      8
`define APB_DATA_W      32
`define APB_IDX_W       5
`define APB_IDX_HI      6
`define APB_IDX_LO      2

// Register map in word indices
`define ADDR_REG_LAST   5'd15
`define ADDR_INSTR      5'd16
`define ADDR_STATUS     5'd17

// Opcodes kept from the full instruction set
`define OPC_CPY         6'h02
`define OPC_ADD         6'h05
`define OPC_SUB         6'h06
`define OPC_ADDC        6'h07
`define OPC_SUBC        6'h08
`define OPC_MUL         6'h09
`define OPC_NOT         6'h0B
`define OPC_AND         6'h0C
`define OPC_OR          6'h0D
`define OPC_XOR         6'h0E
`define OPC_SRL         6'h0F
`define OPC_SRA         6'h10
`define OPC_ROTL        6'h11
`define OPC_ROTR        6'h12
`define OPC_VADD        6'h17
`define OPC_VSUB        6'h18

// Status register bit positions
`define SR_C            11
`define SR_N            10
`define SR_V            9
`define SR_Z            8
`define SR_HI_C         7
`define SR_HI_Z         4
`define SR_LO_C         3
`define SR_LO_Z         0

// Instruction word fields
`define INSTR_OPC_HI    13
`define INSTR_OPC_LO    8
`define INSTR_RI_HI     7
`define INSTR_RI_LO     4
`define INSTR_RJ_HI     3
`define INSTR_RJ_LO     0

`endif

// File: source/risc14Pkg.sv
`default_nettype none

`include "risc14_defs.svh"

package risc14Pkg;

	// Two SIMD lanes of one data word
	typedef struct packed {
		logic [`RISC_LANE_W-1:0] laneHi; // Bits 13 to 7
		logic [`RISC_LANE_W-1:0] laneLo; // Bits 6 to 0
	} risc14Lanes;

	// Scalar ops read the whole word, VADD and VSUB read the lanes
	typedef union packed {
		logic [`RISC_WORD_W-1:0] scalar;
		risc14Lanes lanes;
	} risc14Word;

endpackage

`default_nettype wire

// File: source/apbExecPort.sv
`timescale 1ns/100ps
`default_nettype none

`include "risc14_defs.svh"

module apbExecPort
	import risc14Pkg::*;
(
	input wire logic Clock_not,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`APB_ADDR_W-1:0] paddr,
	input wire logic [`APB_DATA_W-1:0] pwdata,
	input wire risc14Word readDataA,
	input wire risc14Word readDataB,
	input wire logic [`RISC_SR_W-1:0] statusReg,
	output logic [`APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [`RISC_REG_IDX_W-1:0] readIdxA,
	output logic [`RISC_REG_IDX_W-1:0] readIdxB,
	output logic hostWrite,
	output logic [`RISC_REG_IDX_W-1:0] hostIdx,
	output risc14Word hostData,
	output logic execute,
	output logic [`RISC_REG_IDX_W-1:0] destIdx,
	output logic [`RISC_OPC_W-1:0] opcode,
	output risc14Word operandA,
	output risc14Word operandB
);

	logic [`APB_IDX_W-1:0] wordIdx;
	logic [`RISC_OPC_W-1:0] newOpc;
	logic [`RISC_WORD_W-1:0] immValue;
	logic access;
	logic isReg, isInstr, isStatus;
	logic opcLegal, useImm;
	logic instrExec, errCase;
	logic waitDone; // First access cycle of an instruction is over

	assign wordIdx = paddr[`APB_IDX_HI:`APB_IDX_LO];
	assign newOpc = pwdata[`INSTR_OPC_HI:`INSTR_OPC_LO];
	assign immValue = {{(`RISC_WORD_W-`RISC_REG_IDX_W){1'b0}}, pwdata[`INSTR_RJ_HI:`INSTR_RJ_LO]};
	assign access = psel & penable;

	assign isReg = (wordIdx <= `ADDR_REG_LAST);
	assign isInstr = (wordIdx == `ADDR_INSTR);
	assign isStatus = (wordIdx == `ADDR_STATUS);

	always_comb begin
		opcLegal = 1'b1;
		useImm = 1'b0;
		case (newOpc)
			`OPC_ADDC, `OPC_SUBC, `OPC_SRL, `OPC_SRA, `OPC_ROTL, `OPC_ROTR: useImm = 1'b1;
			`OPC_CPY, `OPC_ADD, `OPC_SUB, `OPC_MUL: ;
			`OPC_NOT, `OPC_AND, `OPC_OR, `OPC_XOR: ;
			`OPC_VADD, `OPC_VSUB: ;
			default: opcLegal = 1'b0;
		endcase
	end

	assign instrExec = isInstr & pwrite & opcLegal;
	assign errCase = (isStatus & pwrite) | (isInstr & ~pwrite) | (wordIdx > `ADDR_STATUS)
		| (isInstr & pwrite & ~opcLegal);

	// Only a legal instruction write inserts the wait state
	assign pready = access & (~instrExec | waitDone);
	assign pslverr = access & errCase;
	assign execute = access & instrExec & waitDone;

	assign hostWrite = access & pwrite & isReg;
	assign hostIdx = wordIdx[`RISC_REG_IDX_W-1:0];
	assign hostData = risc14Word'(pwdata[`RISC_WORD_W-1:0]);

	// Port A serves host reads outside instruction transfers
	assign readIdxA = isInstr ? pwdata[`INSTR_RI_HI:`INSTR_RI_LO] : hostIdx;
	assign readIdxB = pwdata[`INSTR_RJ_HI:`INSTR_RJ_LO];

	always_ff @(posedge Clock_not) begin
		if (!rstN) begin
			waitDone <= 1'b0;
		end else if (pready | ~psel) begin
			waitDone <= 1'b0;
		end else if (access & instrExec) begin
			waitDone <= 1'b1;
		end
	end

	always_ff @(posedge Clock_not) begin
		if (access & instrExec & ~waitDone) begin // Latch at end of first access cycle
			opcode <= newOpc;
			destIdx <= pwdata[`INSTR_RI_HI:`INSTR_RI_LO];
			operandA <= readDataA;
			if (useImm) begin
				operandB <= risc14Word'(immValue); // Zero-extended Rj field
			end else begin
				operandB <= readDataB;
			end
		end
	end

	always_comb begin
		prdata = '0;
		if (access & ~pwrite & isReg) begin
			prdata = {{(`APB_DATA_W-`RISC_WORD_W){1'b0}}, readDataA.scalar};
		end else if (access & ~pwrite & isStatus) begin
			prdata = {{(`APB_DATA_W-`RISC_SR_W){1'b0}}, statusReg};
		end
	end

endmodule

`default_nettype wire

// File: source/scalarAlu.sv
`timescale 1ns/100ps
`default_nettype none

`include "risc14_defs.svh"

module scalarAlu
	import risc14Pkg::*;
(
	input wire logic [`RISC_OPC_W-1:0] opcode,
	input wire risc14Word operandA,
	input wire risc14Word operandB,
	output risc14Word result,
	output logic [3:0] scalarStatus, // C, N, V, Z
	output logic [3:0] statusMask,
	output logic scalarHit
);

	localparam logic [3:0] maskAll = 4'b1111;
	localparam logic [3:0] maskNz = 4'b0101; // C and V kept
	localparam logic [3:0] maskNone = 4'b0000;

	logic [`RISC_WORD_W-1:0] a, b;
	logic [`RISC_WORD_W-1:0] res;
	logic [`RISC_WORD_W:0] sum;
	logic [`RISC_WORD_W:0] diff;
	logic [2*`RISC_WORD_W-1:0] product;
	logic [2*`RISC_WORD_W-1:0] rotLeft;
	logic [2*`RISC_WORD_W-1:0] rotRight;
	logic [1:0] shamt;
	logic carry;
	logic overflow;
	logic addOvf, subOvf;

	assign a = operandA.scalar;
	assign b = operandB.scalar;
	assign shamt = b[1:0]; // Only shifts of 0 to 3

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // MSB is the borrow
	assign product = a * b;

	// Doubled word so a plain shift gives the rotate
	assign rotLeft = {a, a} << shamt;
	assign rotRight = {a, a} >> shamt;

	assign addOvf = (a[`RISC_WORD_W-1] == b[`RISC_WORD_W-1])
		& (sum[`RISC_WORD_W-1] != a[`RISC_WORD_W-1]);
	assign subOvf = (a[`RISC_WORD_W-1] != b[`RISC_WORD_W-1])
		& (diff[`RISC_WORD_W-1] != a[`RISC_WORD_W-1]);

	always_comb begin
		res = '0;
		carry = 1'b0;
		overflow = 1'b0;
		statusMask = maskNone;
		scalarHit = 1'b1;
		case (opcode)
			`OPC_ADD, `OPC_ADDC: begin
				res = sum[`RISC_WORD_W-1:0];
				carry = sum[`RISC_WORD_W];
				overflow = addOvf;
				statusMask = maskAll;
			end
			`OPC_SUB, `OPC_SUBC: begin
				res = diff[`RISC_WORD_W-1:0];
				carry = diff[`RISC_WORD_W];
				overflow = subOvf;
				statusMask = maskAll;
			end
			`OPC_MUL: begin
				res = product[`RISC_WORD_W-1:0]; // Low half only
				statusMask = maskNz;
			end
			`OPC_NOT: begin
				res = ~a;
				statusMask = maskNz;
			end
			`OPC_AND: begin
				res = a & b;
				statusMask = maskNz;
			end
			`OPC_OR: begin
				res = a | b;
				statusMask = maskNz;
			end
			`OPC_XOR: begin
				res = a ^ b;
				statusMask = maskNz;
			end
			`OPC_SRL: res = a >> shamt;
			`OPC_SRA: res = $unsigned($signed(a) >>> shamt);
			`OPC_ROTL: res = rotLeft[2*`RISC_WORD_W-1:`RISC_WORD_W];
			`OPC_ROTR: res = rotRight[`RISC_WORD_W-1:0];
			`OPC_CPY: res = b; // Rj into Ri
			default: scalarHit = 1'b0;
		endcase
	end

	assign result = risc14Word'(res);

	// Flags come from the new result
	assign scalarStatus = {carry, res[`RISC_WORD_W-1], overflow, (res == '0)};

endmodule

`default_nettype wire

// File: source/vectorAlu.sv
`timescale 1ns/100ps
`default_nettype none

`include "risc14_defs.svh"

module vectorAlu
	import risc14Pkg::*;
(
	input wire logic [`RISC_OPC_W-1:0] opcode,
	input wire risc14Word operandA,
	input wire risc14Word operandB,
	output risc14Word result,
	output logic [7:0] laneStatus, // High lane C N V Z, then low lane
	output logic vectorHit
);

	// Sum or difference of one lane, followed by its C, N, V and Z
	function automatic logic [`RISC_LANE_W+3:0] laneOp(
		input logic [`RISC_LANE_W-1:0] x,
		input logic [`RISC_LANE_W-1:0] y,
		input logic sub
	);
		logic [`RISC_LANE_W:0] full;
		logic ovf;
		if (sub) begin
			full = {1'b0, x} - {1'b0, y};
			ovf = (x[`RISC_LANE_W-1] != y[`RISC_LANE_W-1])
				& (full[`RISC_LANE_W-1] != x[`RISC_LANE_W-1]);
		end else begin
			full = {1'b0, x} + {1'b0, y};
			ovf = (x[`RISC_LANE_W-1] == y[`RISC_LANE_W-1])
				& (full[`RISC_LANE_W-1] != x[`RISC_LANE_W-1]);
		end
		return {full[`RISC_LANE_W-1:0], full[`RISC_LANE_W], full[`RISC_LANE_W-1], ovf,
			(full[`RISC_LANE_W-1:0] == '0)};
	endfunction

	logic isSub;
	logic [`RISC_LANE_W+3:0] hiOut;
	logic [`RISC_LANE_W+3:0] loOut;

	assign vectorHit = (opcode == `OPC_VADD) | (opcode == `OPC_VSUB);
	assign isSub = (opcode == `OPC_VSUB);

	// Lanes never pass a carry to each other
	assign hiOut = laneOp(operandA.lanes.laneHi, operandB.lanes.laneHi, isSub);
	assign loOut = laneOp(operandA.lanes.laneLo, operandB.lanes.laneLo, isSub);

	always_comb begin
		result.lanes.laneHi = hiOut[`RISC_LANE_W+3:4];
		result.lanes.laneLo = loOut[`RISC_LANE_W+3:4];
	end

	assign laneStatus = {hiOut[3:0], loOut[3:0]};

endmodule

`default_nettype wire

// File: source/regWriteBack.sv
`timescale 1ns/100ps
`default_nettype none

`include "risc14_defs.svh"

module regWriteBack
	import risc14Pkg::*;
(
	input wire logic Clock_not,
	input wire logic rstN,
	input wire logic [`RISC_REG_IDX_W-1:0] readIdxA,
	input wire logic [`RISC_REG_IDX_W-1:0] readIdxB,
	input wire logic hostWrite,
	input wire logic [`RISC_REG_IDX_W-1:0] hostIdx,
	input wire risc14Word hostData,
	input wire logic execute,
	input wire logic [`RISC_REG_IDX_W-1:0] destIdx,
	input wire risc14Word scalarResult,
	input wire logic [3:0] scalarStatus,
	input wire logic [3:0] statusMask,
	input wire logic scalarHit,
	input wire risc14Word vectorResult,
	input wire logic [7:0] laneStatus,
	input wire logic vectorHit,
	output risc14Word readDataA,
	output risc14Word readDataB,
	output logic [`RISC_SR_W-1:0] statusReg
);

	risc14Word regFile [`RISC_REG_CNT]; // R0 to R15

	assign readDataA = regFile[readIdxA];
	assign readDataB = regFile[readIdxB];

	// Host writes and executions never share a cycle
	always_ff @(posedge Clock_not) begin
		if (!rstN) begin
			for (int i = 0; i < `RISC_REG_CNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (hostWrite) begin
			regFile[hostIdx] <= hostData;
		end else if (execute && scalarHit) begin
			regFile[destIdx] <= scalarResult;
		end else if (execute && vectorHit) begin
			regFile[destIdx] <= vectorResult;
		end
	end

	always_ff @(posedge Clock_not) begin
		if (!rstN) begin
			statusReg <= '0;
		end else if (execute && scalarHit) begin
			// Unmasked flags keep their old value
			statusReg[`SR_C:`SR_Z] <= (scalarStatus & statusMask)
				| (statusReg[`SR_C:`SR_Z] & ~statusMask);
		end else if (execute && vectorHit) begin
			statusReg[`SR_HI_C:`SR_LO_Z] <= laneStatus; // Both lanes at once
		end
	end

endmodule

`default_nettype wire

// File: source/risc14Exec.sv
`timescale 1ns/100ps
`default_nettype none

`include "risc14_defs.svh"

module risc14Exec
	import risc14Pkg::*;
(
	input wire logic Clock_not,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`APB_ADDR_W-1:0] paddr,
	input wire logic [`APB_DATA_W-1:0] pwdata,
	output logic [`APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// Register file ports
	logic [`RISC_REG_IDX_W-1:0] readIdxA, readIdxB;
	risc14Word readDataA, readDataB;
	logic hostWrite;
	logic [`RISC_REG_IDX_W-1:0] hostIdx;
	risc14Word hostData;
	logic [`RISC_SR_W-1:0] statusReg;

	// Issue to the ALUs
	logic execute;
	logic [`RISC_REG_IDX_W-1:0] destIdx;
	logic [`RISC_OPC_W-1:0] opcode;
	risc14Word operandA, operandB;

	// ALU results
	risc14Word scalarResult, vectorResult;
	logic [3:0] scalarStatus, statusMask;
	logic [7:0] laneStatus;
	logic scalarHit, vectorHit;

	apbExecPort execPort (
		.Clock_not(Clock_not), .rstN(rstN),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.readDataA(readDataA), .readDataB(readDataB), .statusReg(statusReg),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.readIdxA(readIdxA), .readIdxB(readIdxB),
		.hostWrite(hostWrite), .hostIdx(hostIdx), .hostData(hostData),
		.execute(execute), .destIdx(destIdx), .opcode(opcode),
		.operandA(operandA), .operandB(operandB)
	);

	scalarAlu scalarUnit (
		.opcode(opcode), .operandA(operandA), .operandB(operandB),
		.result(scalarResult), .scalarStatus(scalarStatus),
		.statusMask(statusMask), .scalarHit(scalarHit)
	);

	vectorAlu vectorUnit (
		.opcode(opcode), .operandA(operandA), .operandB(operandB),
		.result(vectorResult), .laneStatus(laneStatus), .vectorHit(vectorHit)
	);

	regWriteBack writeBack (
		.Clock_not(Clock_not), .rstN(rstN),
		.readIdxA(readIdxA), .readIdxB(readIdxB),
		.hostWrite(hostWrite), .hostIdx(hostIdx), .hostData(hostData),
		.execute(execute), .destIdx(destIdx),
		.scalarResult(scalarResult), .scalarStatus(scalarStatus),
		.statusMask(statusMask), .scalarHit(scalarHit),
		.vectorResult(vectorResult), .laneStatus(laneStatus), .vectorHit(vectorHit),
		.readDataA(readDataA), .readDataB(readDataB), .statusReg(statusReg)
	);

endmodule

`default_nettype wire

// File: sim/risc14ExecChecker.sv
`timescale 1ns/100ps
`default_nettype none

`include "risc14_defs.svh"

module risc14ExecChecker (
	input wire logic Clock_not,
	input wire logic rstN,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`APB_ADDR_W-1:0] paddr,
	input wire logic [`APB_DATA_W-1:0] pwdata,
	input wire logic [`APB_DATA_W-1:0] prdata,
	input wire logic pready,
	input wire logic pslverr,
	output int mismatchCount,
	output int otherCount
);

	logic [13:0] regs [16]; // Expected R0 to R15
	logic [11:0] sr;
	int mismatches = 0;
	int others = 0;
	int accessCycles = 0;

	assign mismatchCount = mismatches;
	assign otherCount = others;

	function automatic logic isKept(input logic [5:0] opc);
		case (opc)
			`OPC_CPY, `OPC_ADD, `OPC_SUB, `OPC_ADDC, `OPC_SUBC, `OPC_MUL, `OPC_NOT, `OPC_AND,
			`OPC_OR, `OPC_XOR, `OPC_SRL, `OPC_SRA, `OPC_ROTL, `OPC_ROTR, `OPC_VADD, `OPC_VSUB:
				return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Signed result outside the range of a word of the given width
	function automatic logic signedOvf(input int x, input int y, input logic sub, input int bits);
		int r;
		int lim;
		r = sub ? x - y : x + y;
		lim = 1 << (bits - 1);
		return (r >= lim) || (r < -lim);
	endfunction

	// Result of one 7-bit lane above its C, N, V and Z
	function automatic logic [10:0] laneModel(input logic [6:0] x, input logic [6:0] y,
		input logic sub);
		logic [6:0] r;
		logic c;
		logic v;
		v = signedOvf($signed(x), $signed(y), sub, 7);
		if (sub) begin
			r = x - y;
			c = (x < y); // Borrow
		end else begin
			{c, r} = {1'b0, x} + {1'b0, y};
		end
		return {r, c, r[6], v, (r == 7'd0)};
	endfunction

	task automatic runInstr(input logic [5:0] opc, input logic [3:0] ri, input logic [3:0] rj);
		logic [13:0] a;
		logic [13:0] b;
		logic [13:0] res;
		logic [27:0] prod;
		logic [10:0] hi;
		logic [10:0] lo;
		logic [1:0] sh;
		logic c;
		logic v;
		a = regs[ri];
		b = regs[rj];
		sh = rj[1:0]; // Shift amount from the Rj field
		c = sr[`SR_C]; // Old flags, kept unless arithmetic
		v = sr[`SR_V];
		if (opc == `OPC_ADDC || opc == `OPC_SUBC) begin
			b = {10'd0, rj};
		end
		prod = {14'd0, a} * {14'd0, b};
		hi = laneModel(a[13:7], b[13:7], opc == `OPC_VSUB);
		lo = laneModel(a[6:0], b[6:0], opc == `OPC_VSUB);
		case (opc)
			`OPC_ADD, `OPC_ADDC: begin
				{c, res} = {1'b0, a} + {1'b0, b};
				v = signedOvf($signed(a), $signed(b), 1'b0, 14);
			end
			`OPC_SUB, `OPC_SUBC: begin
				res = a - b;
				c = (a < b);
				v = signedOvf($signed(a), $signed(b), 1'b1, 14);
			end
			`OPC_MUL: res = prod[13:0];
			`OPC_NOT: res = ~a;
			`OPC_AND: res = a & b;
			`OPC_OR: res = a | b;
			`OPC_XOR: res = a ^ b;
			`OPC_SRL: res = a >> sh;
			`OPC_SRA: res = (a >> sh) | ({14{a[13]}} & ~(14'h3FFF >> sh));
			`OPC_ROTL: res = (a << sh) | (a >> (14 - sh));
			`OPC_ROTR: res = (a >> sh) | (a << (14 - sh));
			`OPC_CPY: res = b;
			default: res = {hi[10:4], lo[10:4]}; // VADD and VSUB
		endcase
		regs[ri] = res;
		if (opc == `OPC_VADD || opc == `OPC_VSUB) begin
			sr[7:0] = {hi[3:0], lo[3:0]};
		end else if (opc != `OPC_CPY && opc < `OPC_SRL) begin
			sr[11:8] = {c, res[13], v, (res == 14'd0)};
		end
	endtask

	task automatic checkTransfer();
		logic [4:0] idx;
		logic expErr;
		logic [31:0] expData;
		int expCycles;
		idx = paddr[`APB_IDX_HI:`APB_IDX_LO];
		expData = 32'd0;
		expCycles = 1;
		if (pwrite) begin
			expErr = (idx >= `ADDR_STATUS) || (idx == `ADDR_INSTR && !isKept(pwdata[13:8]));
		end else begin
			expErr = (idx > `ADDR_STATUS) || (idx == `ADDR_INSTR);
		end
		if (pslverr !== expErr) begin
			$display("mismatch pslverr at index %0d: expected %h, got %h",
				idx, expErr, pslverr);
			mismatches++;
		end
		if (!pwrite) begin
			if (idx <= `ADDR_REG_LAST) begin
				expData = {18'd0, regs[idx[3:0]]};
			end else if (idx == `ADDR_STATUS) begin
				expData = {20'd0, sr};
			end
			if (prdata !== expData) begin
				$display("mismatch prdata at index %0d: expected %h, got %h",
					idx, expData, prdata);
				mismatches++;
			end
		end else if (!expErr && idx <= `ADDR_REG_LAST) begin
			regs[idx[3:0]] = pwdata[13:0];
		end else if (!expErr) begin
			expCycles = 2; // One wait state before execution
			runInstr(pwdata[13:8], pwdata[7:4], pwdata[3:0]);
		end
		if (accessCycles != expCycles) begin
			$display("transfer at index %0d took %0d access cycles instead of %0d",
				idx, accessCycles, expCycles);
			others++;
		end
	endtask

	always @(posedge Clock_not) begin
		if (!rstN) begin
			regs = '{default: '0};
			sr = '0;
			accessCycles = 0;
		end else begin
			if (pready && !(psel && penable)) begin
				$display("pready was high outside an access phase");
				others++;
			end
			if (psel && penable) begin
				accessCycles++;
				if (pready) begin
					checkTransfer();
					accessCycles = 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: sim/risc14ExecTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "risc14_defs.svh"

module risc14ExecTb;

	localparam int accessLimit = 6; // Access cycles allowed before pready
	// Scalar opcodes first, the two vector opcodes last
	localparam logic [5:0] keptOps [16] = '{`OPC_ADD, `OPC_SUB, `OPC_ADDC, `OPC_SUBC, `OPC_MUL,
		`OPC_NOT, `OPC_AND, `OPC_OR, `OPC_XOR, `OPC_SRL, `OPC_SRA, `OPC_ROTL, `OPC_ROTR,
		`OPC_CPY, `OPC_VADD, `OPC_VSUB};
	localparam logic [5:0] badOps [8] = '{6'h00, 6'h01, 6'h03, 6'h0A,
		6'h13, 6'h19, 6'h2A, 6'h3F};

	logic Clock_not;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [`APB_DATA_W-1:0] pwdata;
	logic [`APB_DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;
	int mismatchCount;
	int otherCount;

	risc14Exec u_dut (
		.Clock_not(Clock_not), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	risc14ExecChecker apbChecker (
		.Clock_not(Clock_not), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.mismatchCount(mismatchCount), .otherCount(otherCount)
	);

	initial begin
		Clock_not = 1'b0;
		forever #20 Clock_not = ~Clock_not;
	end

	task automatic apbAccess(input logic write, input logic [4:0] idx, input logic [31:0] data);
		int waited;
		@(posedge Clock_not);
		psel <= 1'b1; // Setup phase
		penable <= 1'b0;
		pwrite <= write;
		paddr <= {1'b0, idx, 2'b00};
		pwdata <= data;
		@(posedge Clock_not);
		penable <= 1'b1;
		waited = 0;
		do begin
			@(negedge Clock_not); // Outputs settled at mid-cycle
			waited++;
		end while (!pready && waited < accessLimit);
		if (!pready) begin
			$display("timeout: no pready after %0d access cycles at index %0d", waited, idx);
			$display("test failed");
			$finish;
		end else begin
			@(posedge Clock_not);
			psel <= 1'b0;
			penable <= 1'b0;
		end
	endtask

	task automatic readAll();
		for (int i = 0; i <= `RISC_REG_CNT - 1; i++) begin
			apbAccess(1'b0, 5'(i), 32'd0);
		end
		apbAccess(1'b0, `ADDR_STATUS, 32'd0);
	endtask

	// Random Ri and Rj, then read back the destination and status
	task automatic issueInstr(input logic [5:0] opc);
		logic [3:0] ri;
		logic [3:0] rj;
		ri = 4'($urandom_range(15, 0));
		rj = 4'($urandom_range(15, 0));
		apbAccess(1'b1, `ADDR_INSTR, {18'($urandom()), opc, ri, rj});
		apbAccess(1'b0, {1'b0, ri}, 32'd0);
		apbAccess(1'b0, `ADDR_STATUS, 32'd0);
	endtask

	initial begin
		int pick;
		logic [4:0] regIdx;
		void'($urandom(32'h5a90_cb3b));
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (5) @(posedge Clock_not);
		rstN <= 1'b1;
		readAll();
		repeat (40) begin
			regIdx = 5'($urandom_range(15, 0));
			apbAccess(1'b1, regIdx, $urandom());
			apbAccess(1'b0, regIdx, 32'd0); // Read back the same register
		end
		repeat (260) begin
			pick = $urandom_range(9, 0);
			if (pick < 2) begin
				apbAccess(1'b1, 5'($urandom_range(15, 0)), $urandom()); // Fresh operands
			end else if (pick < 8) begin
				issueInstr(keptOps[4'($urandom_range(13, 0))]);
			end else begin
				issueInstr(keptOps[4'(14 + $urandom_range(1, 0))]);
			end
		end
		repeat (40) begin
			case ($urandom_range(3, 0))
				0: apbAccess(1'b1, `ADDR_INSTR,
					{18'($urandom()), badOps[3'($urandom_range(7, 0))], 8'($urandom())});
				1: apbAccess(1'b1, `ADDR_STATUS, $urandom());
				2: apbAccess(1'b0, `ADDR_INSTR, 32'd0);
				default: apbAccess(1'($urandom_range(1, 0)), 5'($urandom_range(31, 18)),
					$urandom());
			endcase
		end
		readAll(); // State must be untouched by the errors
		repeat (2) @(posedge Clock_not);
		$display("error counts: %0d mismatches, %0d other failures", mismatchCount, otherCount);
		if (mismatchCount == 0 && otherCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: risc14Exec.f
+incdir+source
source/risc14Pkg.sv
source/apbExecPort.sv
source/scalarAlu.sv
source/vectorAlu.sv
source/regWriteBack.sv
source/risc14Exec.sv
sim/risc14ExecChecker.sv
sim/risc14ExecTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1

simOut=""
verilator --binary --timing --timescale 1ns/100ps -j 0 --top-module risc14ExecTb \
	-o risc14ExecSim -f risc14Exec.f \
	&& simOut="$(./obj_dir/risc14ExecSim)"
printf '%s\n' "$simOut"
grep -qx "test passed" <<< "$simOut" && exit 0 || exit 1
